// ==== source/machine_csr_pkg.sv ====
/*
 * Machine-mode CSR package.
 * Shared widths, CSR numbers, command and exception encodings,
 * and the bit positions of the implemented register fields.
 */
`default_nettype none

package machine_csr_pkg;

    // Register width and boot vector defaults.
    localparam int unsigned XLEN_DEFAULT = 64;
    localparam logic [63:0] BOOT_ADDRESS_DEFAULT = 64'h0000_0000_8000_0000;

    // Vectors with a meaning of their own.
    typedef logic [11:0] csr_address_t;
    typedef logic [1:0]  mtvec_mode_t;
    typedef logic [1:0]  privilege_t;
    typedef logic [1:0]  misa_mxl_t;

    // Supported CSR numbers.
    localparam csr_address_t CSR_MSTATUS  = 12'h300;
    localparam csr_address_t CSR_MISA     = 12'h301;
    localparam csr_address_t CSR_MIE      = 12'h304;
    localparam csr_address_t CSR_MTVEC    = 12'h305;
    localparam csr_address_t CSR_MSCRATCH = 12'h340;
    localparam csr_address_t CSR_MEPC     = 12'h341;
    localparam csr_address_t CSR_MCAUSE   = 12'h342;
    localparam csr_address_t CSR_MTVAL    = 12'h343;

    // Command from the core.
    typedef enum logic [1:0]
    {
        CSR_NONE       = 2'b00,
        CSR_READ       = 2'b01,
        CSR_WRITE      = 2'b10,
        CSR_READ_WRITE = 2'b11
    } csr_command_t;

    // Register addressed by the current request.
    typedef enum logic [2:0]
    {
        SEL_MSTATUS,
        SEL_MISA,
        SEL_MIE,
        SEL_MTVEC,
        SEL_MSCRATCH,
        SEL_MEPC,
        SEL_MCAUSE,
        SEL_MTVAL
    } csr_select_t;

    // Synchronous exception codes.
    typedef enum logic [3:0]
    {
        CAUSE_INSTRUCTION_ADDRESS_MISALIGNED = 4'd0,
        CAUSE_INSTRUCTION_ACCESS_FAULT       = 4'd1,
        CAUSE_ILLEGAL_INSTRUCTION            = 4'd2,
        CAUSE_BREAKPOINT                     = 4'd3,
        CAUSE_LOAD_ADDRESS_MISALIGNED        = 4'd4,
        CAUSE_LOAD_ACCESS_FAULT              = 4'd5,
        CAUSE_STORE_ADDRESS_MISALIGNED       = 4'd6,
        CAUSE_STORE_ACCESS_FAULT             = 4'd7,
        CAUSE_ECALL_MACHINE                  = 4'd11,
        CAUSE_INSTRUCTION_PAGE_FAULT         = 4'd12,
        CAUSE_LOAD_PAGE_FAULT                = 4'd13,
        CAUSE_STORE_PAGE_FAULT               = 4'd15
    } exception_cause_t;

    // mstatus fields.
    localparam int unsigned MSTATUS_MIE_BIT  = 3;
    localparam int unsigned MSTATUS_MPIE_BIT = 7;
    localparam int unsigned MSTATUS_MPP_LSB  = 11;
    localparam int unsigned MSTATUS_MPP_MSB  = 12;

    // mie register fields.
    localparam int unsigned MIE_MSIE_BIT = 3;
    localparam int unsigned MIE_MTIE_BIT = 7;
    localparam int unsigned MIE_MEIE_BIT = 11;

    // misa fields, MXL sits in the top two bits.
    localparam int unsigned MISA_I_BIT  = 8;
    localparam misa_mxl_t   MISA_MXL_32 = 2'd1;
    localparam misa_mxl_t   MISA_MXL_64 = 2'd2;

    // mtvec modes and the only privilege level.
    localparam mtvec_mode_t MTVEC_MODE_DIRECT   = 2'd0;
    localparam mtvec_mode_t MTVEC_MODE_VECTORED = 2'd1;
    localparam privilege_t  PRIV_MACHINE        = 2'b11;

    // Decoded request, shared by both register groups and the read mux.
    typedef struct packed
    {
        csr_select_t select;
        logic        read_enable;
        logic        write_enable;
        logic        valid;
    } csr_request_t;

endpackage

`default_nettype wire

// ==== source/csr_decoder.sv ====
/*
 * CSR address and command decoder.
 * Turns the core's address and command into one request for the
 * register groups and the read mux.
 */
`timescale 1ns/1ps
`default_nettype none

module csr_decoder
    import machine_csr_pkg::*;
(
    input  csr_address_t csr_address_i,
    input  csr_command_t csr_command_i,
    output csr_request_t request_o
);

    logic        address_exists;
    logic        command_reads;
    logic        command_writes;
    csr_select_t select;

    // Address to register select.
    always_comb
    begin
        address_exists = 1'b1;
        select         = SEL_MSTATUS;
        case (csr_address_i)
            CSR_MSTATUS:  select = SEL_MSTATUS;
            CSR_MISA:     select = SEL_MISA;
            CSR_MIE:      select = SEL_MIE;
            CSR_MTVEC:    select = SEL_MTVEC;
            CSR_MSCRATCH: select = SEL_MSCRATCH;
            CSR_MEPC:     select = SEL_MEPC;
            CSR_MCAUSE:   select = SEL_MCAUSE;
            CSR_MTVAL:    select = SEL_MTVAL;
            default:      address_exists = 1'b0;
        endcase
    end

    // Command decode.
    always_comb
    begin
        command_reads  = 1'b0;
        command_writes = 1'b0;
        case (csr_command_i)
            CSR_READ:       command_reads  = 1'b1;
            CSR_WRITE:      command_writes = 1'b1;
            CSR_READ_WRITE:
            begin
                command_reads  = 1'b1;
                command_writes = 1'b1;
            end
            default:
            begin
                command_reads  = 1'b0;
                command_writes = 1'b0;
            end
        endcase
    end

    assign request_o.select       = select;
    assign request_o.valid        = address_exists && (csr_command_i != CSR_NONE);
    assign request_o.read_enable  = command_reads && address_exists;
    assign request_o.write_enable = command_writes && address_exists;

endmodule

`default_nettype wire

// ==== source/trap_setup_csrs.sv ====
/*
 * Machine trap setup registers.
 * Holds mstatus, mie and mtvec and drives the constant misa.
 */
`timescale 1ns/1ps
`default_nettype none

module trap_setup_csrs
    import machine_csr_pkg::*;
#(
    parameter int unsigned       XLEN         = XLEN_DEFAULT,
    parameter logic [XLEN - 1:0] BOOT_ADDRESS = BOOT_ADDRESS_DEFAULT[XLEN - 1:0]
)
(
    input  logic              clock_i,
    input  logic              reset_ni,
    input  csr_request_t      request_i,
    input  logic [XLEN - 1:0] write_data_i,
    input  logic              exception_i,
    output logic [XLEN - 1:0] mstatus_o,
    output logic [XLEN - 1:0] misa_o,
    output logic [XLEN - 1:0] mie_o,
    output logic [XLEN - 1:0] mtvec_o
);

    localparam misa_mxl_t MXL = (XLEN == 64) ? MISA_MXL_64 : MISA_MXL_32;

    logic              mstatus_mie_q;
    logic              mstatus_mpie_q;
    privilege_t        mstatus_mpp_q;
    logic              msie_q;
    logic              mtie_q;
    logic              meie_q;
    logic [XLEN - 3:0] mtvec_base_q;
    mtvec_mode_t       mtvec_mode_q;

    logic mstatus_write;
    logic mie_write;
    logic mtvec_write;

    assign mstatus_write = request_i.write_enable && (request_i.select == SEL_MSTATUS);
    assign mie_write     = request_i.write_enable && (request_i.select == SEL_MIE);
    assign mtvec_write   = request_i.write_enable && (request_i.select == SEL_MTVEC);

    // mstatus interrupt stack, a trap takes priority over software.
    always_ff @(posedge clock_i or negedge reset_ni)
    begin
        if (!reset_ni)
        begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mstatus_mpp_q  <= '0;
        end
        else if (exception_i)
        begin
            mstatus_mpie_q <= mstatus_mie_q;
            mstatus_mie_q  <= 1'b0;
            mstatus_mpp_q  <= PRIV_MACHINE;
        end
        else if (mstatus_write)
        begin
            mstatus_mie_q <= write_data_i[MSTATUS_MIE_BIT];
        end
    end

    // Machine interrupt enables only.
    always_ff @(posedge clock_i or negedge reset_ni)
    begin
        if (!reset_ni)
        begin
            msie_q <= 1'b0;
            mtie_q <= 1'b0;
            meie_q <= 1'b0;
        end
        else if (mie_write)
        begin
            msie_q <= write_data_i[MIE_MSIE_BIT];
            mtie_q <= write_data_i[MIE_MTIE_BIT];
            meie_q <= write_data_i[MIE_MEIE_BIT];
        end
    end

    // Trap vector. Reserved modes leave the old mode in place.
    always_ff @(posedge clock_i or negedge reset_ni)
    begin
        if (!reset_ni)
        begin
            mtvec_base_q <= BOOT_ADDRESS[XLEN - 1:2];
            mtvec_mode_q <= MTVEC_MODE_DIRECT;
        end
        else if (mtvec_write)
        begin
            mtvec_base_q <= write_data_i[XLEN - 1:2];
            if (write_data_i[1:0] <= MTVEC_MODE_VECTORED)
                mtvec_mode_q <= write_data_i[1:0];
        end
    end

    always_comb
    begin
        mstatus_o = '0;
        mstatus_o[MSTATUS_MIE_BIT] = mstatus_mie_q;
        mstatus_o[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
        mstatus_o[MSTATUS_MPP_MSB:MSTATUS_MPP_LSB] = mstatus_mpp_q;

        mie_o = '0;
        mie_o[MIE_MSIE_BIT] = msie_q;
        mie_o[MIE_MTIE_BIT] = mtie_q;
        mie_o[MIE_MEIE_BIT] = meie_q;

        // RV32I or RV64I, nothing else.
        misa_o = '0;
        misa_o[XLEN - 1 -: 2] = MXL;
        misa_o[MISA_I_BIT] = 1'b1;
    end

    assign mtvec_o = {mtvec_base_q, mtvec_mode_q};

    // Only DIRECT and VECTORED may ever be held.
    mtvec_mode_legal: assert property (@(posedge clock_i) disable iff (!reset_ni)
        mtvec_mode_q <= MTVEC_MODE_VECTORED);

endmodule

`default_nettype wire

// ==== source/trap_handling_csrs.sv ====
/*
 * Machine trap handling registers.
 * Holds mscratch, mepc, mcause and mtval and captures trap state.
 */
`timescale 1ns/1ps
`default_nettype none

module trap_handling_csrs
    import machine_csr_pkg::*;
#(
    parameter int unsigned XLEN = XLEN_DEFAULT
)
(
    input  logic              clock_i,
    input  logic              reset_ni,
    input  csr_request_t      request_i,
    input  logic [XLEN - 1:0] write_data_i,
    input  logic              exception_i,
    input  exception_cause_t  exception_cause_i,
    input  logic [XLEN - 1:0] exception_pc_i,
    input  logic [XLEN - 1:0] exception_value_i,
    output logic [XLEN - 1:0] mscratch_o,
    output logic [XLEN - 1:0] mepc_o,
    output logic [XLEN - 1:0] mcause_o,
    output logic [XLEN - 1:0] mtval_o
);

    logic [XLEN - 1:0] mscratch_q;
    logic [XLEN - 1:0] mepc_q;
    logic [XLEN - 1:0] mcause_q;
    logic [XLEN - 1:0] mtval_q;
    logic [XLEN - 1:0] trap_value;

    logic mscratch_write;
    logic mepc_write;
    logic mcause_write;
    logic mtval_write;

    assign mscratch_write = request_i.write_enable && (request_i.select == SEL_MSCRATCH);
    assign mepc_write     = request_i.write_enable && (request_i.select == SEL_MEPC);
    assign mcause_write   = request_i.write_enable && (request_i.select == SEL_MCAUSE);
    assign mtval_write    = request_i.write_enable && (request_i.select == SEL_MTVAL);

    // Faulting address for memory faults, PC for breakpoints.
    always_comb
    begin
        case (exception_cause_i)
            CAUSE_INSTRUCTION_ADDRESS_MISALIGNED,
            CAUSE_INSTRUCTION_ACCESS_FAULT,
            CAUSE_LOAD_ADDRESS_MISALIGNED,
            CAUSE_LOAD_ACCESS_FAULT,
            CAUSE_STORE_ADDRESS_MISALIGNED,
            CAUSE_STORE_ACCESS_FAULT,
            CAUSE_INSTRUCTION_PAGE_FAULT,
            CAUSE_LOAD_PAGE_FAULT,
            CAUSE_STORE_PAGE_FAULT:    trap_value = exception_value_i;
            CAUSE_BREAKPOINT:          trap_value = exception_pc_i;
            CAUSE_ILLEGAL_INSTRUCTION,
            CAUSE_ECALL_MACHINE:       trap_value = '0;
            default:                   trap_value = '0;
        endcase
    end

    always_ff @(posedge clock_i or negedge reset_ni)
    begin
        if (!reset_ni)
            mscratch_q <= '0;
        else if (mscratch_write)
            mscratch_q <= write_data_i;
    end

    // Trap capture wins over a software write in the same cycle.
    always_ff @(posedge clock_i or negedge reset_ni)
    begin
        if (!reset_ni)
        begin
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end
        else if (exception_i)
        begin
            mepc_q   <= {exception_pc_i[XLEN - 1:1], 1'b0};
            mcause_q <= XLEN'(exception_cause_i);
            mtval_q  <= trap_value;
        end
        else
        begin
            if (mepc_write)
                mepc_q <= {write_data_i[XLEN - 1:1], 1'b0};
            if (mcause_write)
                mcause_q <= write_data_i;
            if (mtval_write)
                mtval_q <= write_data_i;
        end
    end

    assign mscratch_o = mscratch_q;
    assign mepc_o     = mepc_q;
    assign mcause_o   = mcause_q;
    assign mtval_o    = mtval_q;

    // Return addresses stay at least halfword aligned.
    mepc_aligned: assert property (@(posedge clock_i) disable iff (!reset_ni)
        mepc_q[0] == 1'b0);

endmodule

`default_nettype wire

// ==== source/csr_read_mux.sv ====
/*
 * CSR read mux.
 * Picks the addressed register for the combinational read port.
 */
`timescale 1ns/1ps
`default_nettype none

module csr_read_mux
    import machine_csr_pkg::*;
#(
    parameter int unsigned XLEN = XLEN_DEFAULT
)
(
    input  csr_request_t      request_i,
    input  logic [XLEN - 1:0] mstatus_i,
    input  logic [XLEN - 1:0] misa_i,
    input  logic [XLEN - 1:0] mie_i,
    input  logic [XLEN - 1:0] mtvec_i,
    input  logic [XLEN - 1:0] mscratch_i,
    input  logic [XLEN - 1:0] mepc_i,
    input  logic [XLEN - 1:0] mcause_i,
    input  logic [XLEN - 1:0] mtval_i,
    output logic [XLEN - 1:0] csr_read_data_o,
    output logic              csr_read_data_valid_o
);

    // Zero unless the request actually reads.
    always_comb
    begin
        csr_read_data_o = '0;
        if (request_i.read_enable)
        begin
            case (request_i.select)
                SEL_MSTATUS:  csr_read_data_o = mstatus_i;
                SEL_MISA:     csr_read_data_o = misa_i;
                SEL_MIE:      csr_read_data_o = mie_i;
                SEL_MTVEC:    csr_read_data_o = mtvec_i;
                SEL_MSCRATCH: csr_read_data_o = mscratch_i;
                SEL_MEPC:     csr_read_data_o = mepc_i;
                SEL_MCAUSE:   csr_read_data_o = mcause_i;
                SEL_MTVAL:    csr_read_data_o = mtval_i;
                default:      csr_read_data_o = '0;
            endcase
        end
    end

    assign csr_read_data_valid_o = request_i.valid;

endmodule

`default_nettype wire

// ==== source/machine_csr_file.sv ====
/*
 * Machine-mode CSR file.
 * Decodes core requests, holds the trap registers and returns read data.
 */
`timescale 1ns/1ps
`default_nettype none

module machine_csr_file
    import machine_csr_pkg::*;
#(
    parameter int unsigned       XLEN         = XLEN_DEFAULT,
    parameter logic [XLEN - 1:0] BOOT_ADDRESS = BOOT_ADDRESS_DEFAULT[XLEN - 1:0]
)
(
    input  logic              clock_i,
    input  logic              reset_ni,
    input  csr_address_t      csr_address_i,
    input  csr_command_t      csr_command_i,
    input  logic [XLEN - 1:0] csr_write_data_i,
    input  logic              exception_i,
    input  exception_cause_t  exception_cause_i,
    input  logic [XLEN - 1:0] exception_pc_i,
    input  logic [XLEN - 1:0] exception_value_i,
    output logic [XLEN - 1:0] csr_read_data_o,
    output logic              csr_read_data_valid_o
);

    csr_request_t      request;
    logic [XLEN - 1:0] mstatus;
    logic [XLEN - 1:0] misa;
    logic [XLEN - 1:0] mie;
    logic [XLEN - 1:0] mtvec;
    logic [XLEN - 1:0] mscratch;
    logic [XLEN - 1:0] mepc;
    logic [XLEN - 1:0] mcause;
    logic [XLEN - 1:0] mtval;

    csr_decoder u_decoder
    (
        .csr_address_i (csr_address_i),
        .csr_command_i (csr_command_i),
        .request_o     (request)
    );

    trap_setup_csrs #(
        .XLEN         (XLEN),
        .BOOT_ADDRESS (BOOT_ADDRESS)
    ) u_trap_setup
    (
        .clock_i      (clock_i),
        .reset_ni     (reset_ni),
        .request_i    (request),
        .write_data_i (csr_write_data_i),
        .exception_i  (exception_i),
        .mstatus_o    (mstatus),
        .misa_o       (misa),
        .mie_o        (mie),
        .mtvec_o      (mtvec)
    );

    trap_handling_csrs #(
        .XLEN (XLEN)
    ) u_trap_handling
    (
        .clock_i           (clock_i),
        .reset_ni          (reset_ni),
        .request_i         (request),
        .write_data_i      (csr_write_data_i),
        .exception_i       (exception_i),
        .exception_cause_i (exception_cause_i),
        .exception_pc_i    (exception_pc_i),
        .exception_value_i (exception_value_i),
        .mscratch_o        (mscratch),
        .mepc_o            (mepc),
        .mcause_o          (mcause),
        .mtval_o           (mtval)
    );

    csr_read_mux #(
        .XLEN (XLEN)
    ) u_read_mux
    (
        .request_i             (request),
        .mstatus_i             (mstatus),
        .misa_i                (misa),
        .mie_i                 (mie),
        .mtvec_i               (mtvec),
        .mscratch_i            (mscratch),
        .mepc_i                (mepc),
        .mcause_i              (mcause),
        .mtval_i               (mtval),
        .csr_read_data_o       (csr_read_data_o),
        .csr_read_data_valid_o (csr_read_data_valid_o)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock_gen.sv ====
/*
 * Testbench clock and reset source.
 * Free-running clock and an active-low reset held for a fixed number of cycles.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
    parameter int unsigned PERIOD_NS    = 20,
    parameter int unsigned RESET_CYCLES = 8
)
(
    output logic clock_o,
    output logic reset_no
);

    initial
    begin
        clock_o = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) clock_o = ~clock_o;
        end
    end

    // Release just after a rising edge.
    initial
    begin
        reset_no = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock_o);
        #1 reset_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tests/machine_csr_file_tb.sv ====
/*
 * Testbench for the machine-mode CSR file.
 * Applies a table of CSR accesses and traps, one row per cycle,
 * and checks the combinational read port against expected values.
 */
`timescale 1ns/1ps
`default_nettype none

module machine_csr_file_tb
    import machine_csr_pkg::*;
();

    localparam int unsigned  XLEN          = 64;
    localparam logic [63:0]  BOOT_ADDRESS  = 64'h0000_0000_8000_0000;
    localparam int unsigned  CLOCK_PERIOD  = 20;
    localparam int unsigned  RESET_CYCLES  = 8;
    localparam int unsigned  EDGE_TIMEOUT  = 50;
    localparam int unsigned  RESET_TIMEOUT = 400;
    localparam logic [31:0]  SEED          = 32'hf03f_ced2;
    localparam csr_address_t UNKNOWN_CSR   = 12'h7C0;

    // One cycle of stimulus and the response expected in that cycle.
    typedef struct packed
    {
        csr_command_t     command;
        csr_address_t     address;
        logic [63:0]      write_data;
        logic             exception;
        exception_cause_t cause;
        logic [63:0]      pc;
        logic [63:0]      value;
        logic [63:0]      expected_data;
        logic             expected_valid;
    } test_row_t;

    logic             clock;
    logic             reset_n;
    csr_address_t     csr_address;
    csr_command_t     csr_command;
    logic [63:0]      csr_write_data;
    logic             exception;
    exception_cause_t exception_cause;
    logic [63:0]      exception_pc;
    logic [63:0]      exception_value;
    logic [63:0]      csr_read_data;
    logic             csr_read_data_valid;

    test_row_t   rows[$];
    logic [31:0] rng_state;

    tb_clock_gen #(
        .PERIOD_NS    (CLOCK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen
    (
        .clock_o  (clock),
        .reset_no (reset_n)
    );

    machine_csr_file #(
        .XLEN         (XLEN),
        .BOOT_ADDRESS (BOOT_ADDRESS)
    ) dut
    (
        .clock_i               (clock),
        .reset_ni              (reset_n),
        .csr_address_i         (csr_address),
        .csr_command_i         (csr_command),
        .csr_write_data_i      (csr_write_data),
        .exception_i           (exception),
        .exception_cause_i     (exception_cause),
        .exception_pc_i        (exception_pc),
        .exception_value_i     (exception_value),
        .csr_read_data_o       (csr_read_data),
        .csr_read_data_valid_o (csr_read_data_valid)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        begin
            x = state;
            x = x ^ (x << 13);
            x = x ^ (x >> 17);
            x = x ^ (x << 5);
            return x;
        end
    endfunction

    function logic [63:0] next_random64();
        logic [31:0] high;
        begin
            rng_state = xorshift32(rng_state);
            high = rng_state;
            rng_state = xorshift32(rng_state);
            return {high, rng_state};
        end
    endfunction

    // MIE at 3, MPIE at 7, MPP at 12:11, everything else zero.
    function automatic logic [63:0] mstatus_value(input logic mie, input logic mpie,
                                                  input logic [1:0] mpp);
        begin
            return (64'(mie) << 3) | (64'(mpie) << 7) | (64'(mpp) << 11);
        end
    endfunction

    task automatic report_failure(input string line);
        begin
            $display("%s", line);
            $display("SOME TESTS FAILED");
        end
    endtask

    task automatic add_row(input csr_command_t command, input csr_address_t address,
                           input logic [63:0] write_data, input logic trap,
                           input exception_cause_t cause, input logic [63:0] pc,
                           input logic [63:0] value, input logic [63:0] expected_data,
                           input logic expected_valid);
        test_row_t row;
        begin
            row.command        = command;
            row.address        = address;
            row.write_data     = write_data;
            row.exception      = trap;
            row.cause          = cause;
            row.pc             = pc;
            row.value          = value;
            row.expected_data  = expected_data;
            row.expected_valid = expected_valid;
            rows.push_back(row);
        end
    endtask

    task automatic add_access(input csr_command_t command, input csr_address_t address,
                              input logic [63:0] write_data,
                              input logic [63:0] expected_data, input logic expected_valid);
        begin
            add_row(command, address, write_data, 1'b0, CAUSE_INSTRUCTION_ADDRESS_MISALIGNED,
                    '0, '0, expected_data, expected_valid);
        end
    endtask

    task automatic add_read(input csr_address_t address, input logic [63:0] expected_data);
        begin
            add_access(CSR_READ, address, '0, expected_data, 1'b1);
        end
    endtask

    task automatic add_write(input csr_address_t address, input logic [63:0] write_data);
        begin
            add_access(CSR_WRITE, address, write_data, '0, 1'b1);
        end
    endtask

    // A trap with no CSR access in the same cycle.
    task automatic add_trap(input exception_cause_t cause, input logic [63:0] pc,
                            input logic [63:0] value);
        begin
            add_row(CSR_NONE, '0, '0, 1'b1, cause, pc, value, '0, 1'b0);
        end
    endtask

    task automatic build_table();
        logic [63:0] scratch_data;
        logic [63:0] misa_expected;
        logic [63:0] mie_writable;
        begin
            misa_expected = (64'd2 << 62) | (64'd1 << 8);
            mie_writable  = (64'd1 << 3) | (64'd1 << 7) | (64'd1 << 11);
            scratch_data  = next_random64();

            // Reset values and the constant misa.
            add_read(CSR_MTVEC, BOOT_ADDRESS);
            add_read(CSR_MSTATUS, '0);
            add_read(CSR_MIE, '0);
            add_read(CSR_MSCRATCH, '0);
            add_read(CSR_MEPC, '0);
            add_read(CSR_MCAUSE, '0);
            add_read(CSR_MTVAL, '0);
            add_read(CSR_MISA, misa_expected);
            add_write(CSR_MISA, '1);
            add_read(CSR_MISA, misa_expected);

            // Field masks, unknown address, idle command.
            add_write(CSR_MSTATUS, '1);
            add_read(CSR_MSTATUS, mstatus_value(1'b1, 1'b0, 2'd0));
            add_write(CSR_MIE, '1);
            add_read(CSR_MIE, mie_writable);
            add_access(CSR_READ, UNKNOWN_CSR, '0, '0, 1'b0);
            add_access(CSR_READ_WRITE, UNKNOWN_CSR, '1, '0, 1'b0);
            add_access(CSR_NONE, CSR_MIE, '0, '0, 1'b0);

            // Writable registers.
            add_write(CSR_MSCRATCH, scratch_data);
            add_read(CSR_MSCRATCH, scratch_data);
            add_write(CSR_MEPC, 64'h0000_0000_1234_5679);
            add_read(CSR_MEPC, 64'h0000_0000_1234_5678);
            add_write(CSR_MTVEC, 64'h0000_0000_0000_1001);
            add_read(CSR_MTVEC, 64'h0000_0000_0000_1001);
            add_write(CSR_MTVEC, 64'h0000_0000_0000_2003);
            add_read(CSR_MTVEC, 64'h0000_0000_0000_2001);

            // Swap returns the old value.
            add_access(CSR_READ_WRITE, CSR_MSCRATCH, 64'hdead_beef_0123_4567, scratch_data, 1'b1);
            add_read(CSR_MSCRATCH, 64'hdead_beef_0123_4567);

            // Load access fault with interrupts enabled.
            add_write(CSR_MSTATUS, mstatus_value(1'b1, 1'b0, 2'd0));
            add_trap(CAUSE_LOAD_ACCESS_FAULT, 64'h0000_0000_8000_0105, 64'h0000_0000_4000_0abc);
            add_read(CSR_MEPC, 64'h0000_0000_8000_0104);
            add_read(CSR_MCAUSE, 64'd5);
            add_read(CSR_MTVAL, 64'h0000_0000_4000_0abc);
            add_read(CSR_MSTATUS, mstatus_value(1'b0, 1'b1, 2'd3));

            // Breakpoint puts the PC in mtval. MPIE now takes MIE 0.
            add_trap(CAUSE_BREAKPOINT, 64'h0000_0000_8000_0200, 64'h0000_0000_0000_1234);
            add_read(CSR_MTVAL, 64'h0000_0000_8000_0200);
            add_read(CSR_MSTATUS, mstatus_value(1'b0, 1'b0, 2'd3));
            add_trap(CAUSE_ILLEGAL_INSTRUCTION, 64'h0000_0000_8000_0300, 64'h5555);
            add_read(CSR_MTVAL, '0);
            add_read(CSR_MEPC, 64'h0000_0000_8000_0300);
            add_read(CSR_MCAUSE, 64'd2);

            // Trap and software write to mcause in one cycle.
            add_row(CSR_WRITE, CSR_MCAUSE, 64'h1f, 1'b1, CAUSE_ECALL_MACHINE,
                    64'h0000_0000_8000_0400, 64'h77, '0, 1'b1);
            add_read(CSR_MCAUSE, 64'd11);
            add_read(CSR_MEPC, 64'h0000_0000_8000_0400);
            add_read(CSR_MTVAL, '0);

            // Software writes without a trap.
            add_write(CSR_MTVAL, 64'h0000_0000_0000_abcd);
            add_read(CSR_MTVAL, 64'h0000_0000_0000_abcd);
            add_write(CSR_MCAUSE, 64'd7);
            add_read(CSR_MCAUSE, 64'd7);
        end
    endtask

    // Polls at half-nanosecond offsets, so a poll never lands on a clock edge.
    task automatic wait_for_rising_edge();
        int unsigned waited;
        begin
            waited = 0;
            while (clock === 1'b1 && waited < EDGE_TIMEOUT)
            begin
                #1;
                waited++;
            end
            while (clock !== 1'b1 && waited < EDGE_TIMEOUT)
            begin
                #1;
                waited++;
            end
            if (waited >= EDGE_TIMEOUT)
            begin
                report_failure("Timed out waiting for a rising clock edge.");
                $fatal(1, "clock stopped");
            end
        end
    endtask

    task automatic wait_for_reset_release();
        int unsigned waited;
        begin
            waited = 0;
            while (reset_n !== 1'b1 && waited < RESET_TIMEOUT)
            begin
                #1;
                waited++;
            end
            if (reset_n !== 1'b1)
            begin
                report_failure("Reset was never released.");
                $fatal(1, "reset stuck");
            end
        end
    endtask

    task automatic apply_row(input test_row_t row);
        begin
            csr_command     = row.command;
            csr_address     = row.address;
            csr_write_data  = row.write_data;
            exception       = row.exception;
            exception_cause = row.cause;
            exception_pc    = row.pc;
            exception_value = row.value;
        end
    endtask

    task automatic check_row(input int unsigned index, input test_row_t row);
        begin
            assert (csr_read_data_valid === row.expected_valid)
            else
            begin
                report_failure($sformatf("[ERROR] %.1f ns: row %0d read valid %b, expected %b",
                                         $realtime, index, csr_read_data_valid,
                                         row.expected_valid));
                $fatal(1, "read valid mismatch");
            end
            assert (csr_read_data === row.expected_data)
            else
            begin
                report_failure($sformatf("[ERROR] %.1f ns: row %0d read data %h, expected %h",
                                         $realtime, index, csr_read_data, row.expected_data));
                $fatal(1, "read data mismatch");
            end
        end
    endtask

    initial
    begin
        int unsigned index;
        csr_address     = '0;
        csr_command     = CSR_NONE;
        csr_write_data  = '0;
        exception       = 1'b0;
        exception_cause = CAUSE_INSTRUCTION_ADDRESS_MISALIGNED;
        exception_pc    = '0;
        exception_value = '0;
        rng_state       = SEED;
        build_table();

        #0.5;
        wait_for_reset_release();
        for (index = 0; index < rows.size(); index++)
        begin
            wait_for_rising_edge();
            #0.5;
            apply_row(rows[index]);
            #14.5;
            check_row(index, rows[index]);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
source/machine_csr_pkg.sv
source/csr_decoder.sv
source/trap_setup_csrs.sv
source/trap_handling_csrs.sv
source/csr_read_mux.sv
source/machine_csr_file.sv
tests/tb_clock_gen.sv
tests/machine_csr_file_tb.sv
